// File: hw/ack_emitter.sv
`timescale 1ns/1ps

module ack_emitter #(
     parameter int FLOW_ID_W = 4
)(
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       q_empty
    ,input  logic [FLOW_ID_W-1:0]       q_rd_flowid
    ,input  tcp_hdr_pkg::seq_num_t      q_rd_num
    ,input  tcp_engine_pkg::ack_kind_e  q_rd_kind
    ,output logic                       q_rd_en

    ,output logic                       ack_req
    ,output logic [FLOW_ID_W-1:0]       ack_flowid
    ,output tcp_hdr_pkg::seq_num_t      ack_num
    ,output tcp_engine_pkg::ack_kind_e  ack_kind
    ,input  logic                       ack_ack
);

    tcp_engine_pkg::emit_state_e    state_q;

    // pop in the same cycle the head entry is captured.
    assign q_rd_en = (state_q == tcp_engine_pkg::EM_IDLE) && !q_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= tcp_engine_pkg::EM_IDLE;
            ack_req <= 1'b0;
        end else begin
            unique case (state_q)
                tcp_engine_pkg::EM_IDLE: begin
                    if (!q_empty) begin
                        ack_req <= 1'b1;
                        state_q <= tcp_engine_pkg::EM_REQ;
                    end
                end
                tcp_engine_pkg::EM_REQ: begin
                    if (ack_ack) begin
                        ack_req <= 1'b0;
                        state_q <= tcp_engine_pkg::EM_WAIT_DROP;
                    end
                end
                tcp_engine_pkg::EM_WAIT_DROP: begin
                    if (!ack_ack) begin                     // sink has closed the handshake.
                        state_q <= tcp_engine_pkg::EM_IDLE;
                    end
                end
                default: begin
                    state_q <= tcp_engine_pkg::EM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_rd_en) begin
            ack_flowid <= q_rd_flowid;
            ack_num    <= q_rd_num;
            ack_kind   <= q_rd_kind;
        end
    end

endmodule

// File: hw/recv_state_store.sv
`timescale 1ns/1ps

module recv_state_store #(
     parameter int FLOW_ID_W = 4
)(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   st_rd_en
    ,input  logic [FLOW_ID_W-1:0]   st_rd_flowid
    ,output logic                   st_rd_open
    ,output tcp_hdr_pkg::seq_num_t  st_rd_expected

    ,input  logic                   st_wr_en
    ,input  logic [FLOW_ID_W-1:0]   st_wr_flowid
    ,input  logic                   st_wr_open
    ,input  tcp_hdr_pkg::seq_num_t  st_wr_expected
);

    localparam int NUM_FLOWS = 1 << FLOW_ID_W;

    logic   [NUM_FLOWS-1:0]     open_q;
    tcp_hdr_pkg::seq_num_t      expected_mem [NUM_FLOWS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            open_q <= '0;                                   // every flow starts closed.
        end else if (st_wr_en) begin
            open_q[st_wr_flowid] <= st_wr_open;
        end
    end

    always_ff @(posedge clk) begin
        if (st_wr_en) begin
            expected_mem[st_wr_flowid] <= st_wr_expected;
        end
    end

    // the read port is registered, so data follows the request by one cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_rd_open <= 1'b0;
        end else if (st_rd_en) begin
            st_rd_open <= open_q[st_rd_flowid];
        end
    end

    always_ff @(posedge clk) begin
        if (st_rd_en) begin
            st_rd_expected <= expected_mem[st_rd_flowid];
        end
    end

endmodule

// File: hw/rx_hdr_proc.sv
`timescale 1ns/1ps

module rx_hdr_proc #(
     parameter int FLOW_ID_W = 4
)(
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       hdr_req
    ,input  logic [FLOW_ID_W-1:0]       hdr_flowid
    ,input  tcp_hdr_pkg::seq_num_t      hdr_seq
    ,input  tcp_hdr_pkg::payload_len_t  hdr_len
    ,input  tcp_hdr_pkg::tcp_flags_t    hdr_flags
    ,output logic                       hdr_ack

    ,output logic                       st_rd_en
    ,output logic [FLOW_ID_W-1:0]       st_rd_flowid
    ,input  logic                       st_rd_open
    ,input  tcp_hdr_pkg::seq_num_t      st_rd_expected

    ,output logic                       st_wr_en
    ,output logic [FLOW_ID_W-1:0]       st_wr_flowid
    ,output logic                       st_wr_open
    ,output tcp_hdr_pkg::seq_num_t      st_wr_expected

    ,input  logic                       q_full
    ,output logic                       q_wr_en
    ,output logic [FLOW_ID_W-1:0]       q_wr_flowid
    ,output tcp_hdr_pkg::seq_num_t      q_wr_num
    ,output tcp_engine_pkg::ack_kind_e  q_wr_kind
);

    tcp_engine_pkg::hdr_proc_state_e    state_q;

    logic   [FLOW_ID_W-1:0]             flowid_q;
    tcp_hdr_pkg::seq_num_t              seq_q;
    tcp_hdr_pkg::payload_len_t          len_q;
    tcp_hdr_pkg::tcp_flags_t            flags_q;

    logic                               syn;
    logic                               fin;
    logic                               upd;
    logic                               next_open;
    tcp_hdr_pkg::seq_num_t              next_expected;
    tcp_hdr_pkg::seq_num_t              num_d;
    tcp_engine_pkg::ack_kind_e          kind_d;

    assign syn = flags_q[tcp_hdr_pkg::FLAG_SYN_BIT];
    assign fin = flags_q[tcp_hdr_pkg::FLAG_FIN_BIT];

    // the reply and the new flow state are valid in HP_DECIDE once the store data has arrived.
    always_comb begin
        upd           = 1'b0;
        next_open     = st_rd_open;
        next_expected = st_rd_expected;
        kind_d        = tcp_engine_pkg::ACK_RST;
        num_d         = '0;
        if (syn) begin
            upd           = 1'b1;
            next_open     = 1'b1;
            next_expected = seq_q + 32'd1;
            kind_d        = tcp_engine_pkg::ACK_SYN;
            num_d         = seq_q + 32'd1;
        end else if (!st_rd_open) begin
            kind_d = tcp_engine_pkg::ACK_RST;               // data on a closed flow is refused.
        end else if (seq_q != st_rd_expected) begin
            kind_d = tcp_engine_pkg::ACK_DUP;
            num_d  = st_rd_expected;
        end else begin
            upd           = 1'b1;
            next_open     = !fin;
            next_expected = st_rd_expected + tcp_hdr_pkg::seq_num_t'(len_q)
                          + (fin ? 32'd1 : 32'd0);          // FIN takes one sequence number.
            kind_d        = tcp_engine_pkg::ACK_DATA;
            num_d         = next_expected;
        end
    end

    assign st_rd_en       = (state_q == tcp_engine_pkg::HP_READ);
    assign st_rd_flowid   = flowid_q;
    assign st_wr_en       = (state_q == tcp_engine_pkg::HP_DECIDE) && upd;
    assign st_wr_flowid   = flowid_q;
    assign st_wr_open     = next_open;
    assign st_wr_expected = next_expected;

    assign q_wr_en     = (state_q == tcp_engine_pkg::HP_ENQ) && !q_full;
    assign q_wr_flowid = flowid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= tcp_engine_pkg::HP_IDLE;
            hdr_ack <= 1'b0;
        end else begin
            unique case (state_q)
                tcp_engine_pkg::HP_IDLE: begin
                    if (hdr_req) begin
                        state_q <= tcp_engine_pkg::HP_READ;
                    end
                end
                tcp_engine_pkg::HP_READ: begin
                    state_q <= tcp_engine_pkg::HP_DECIDE;
                end
                tcp_engine_pkg::HP_DECIDE: begin
                    state_q <= tcp_engine_pkg::HP_ENQ;
                end
                tcp_engine_pkg::HP_ENQ: begin
                    if (!q_full) begin                      // stall here while the queue is full.
                        hdr_ack <= 1'b1;
                        state_q <= tcp_engine_pkg::HP_WAIT_DROP;
                    end
                end
                tcp_engine_pkg::HP_WAIT_DROP: begin
                    if (!hdr_req) begin
                        hdr_ack <= 1'b0;
                        state_q <= tcp_engine_pkg::HP_IDLE;
                    end
                end
                default: begin
                    state_q <= tcp_engine_pkg::HP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == tcp_engine_pkg::HP_IDLE && hdr_req) begin
            flowid_q <= hdr_flowid;
            seq_q    <= hdr_seq;
            len_q    <= hdr_len;
            flags_q  <= hdr_flags;
        end
        if (state_q == tcp_engine_pkg::HP_DECIDE) begin
            q_wr_num  <= num_d;
            q_wr_kind <= kind_d;
        end
    end

endmodule

// File: hw/rx_send_queue.sv
`timescale 1ns/1ps

module rx_send_queue #(
     parameter int FLOW_ID_W        = 4
    ,parameter int QUEUE_DEPTH_LOG2 = 2
)(
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       q_wr_en
    ,input  logic [FLOW_ID_W-1:0]       q_wr_flowid
    ,input  tcp_hdr_pkg::seq_num_t      q_wr_num
    ,input  tcp_engine_pkg::ack_kind_e  q_wr_kind
    ,output logic                       q_full

    ,input  logic                       q_rd_en
    ,output logic                       q_empty
    ,output logic [FLOW_ID_W-1:0]       q_rd_flowid
    ,output tcp_hdr_pkg::seq_num_t      q_rd_num
    ,output tcp_engine_pkg::ack_kind_e  q_rd_kind
);

    localparam int DEPTH  = 1 << QUEUE_DEPTH_LOG2;
    localparam int NUM_W  = $bits(tcp_hdr_pkg::seq_num_t);
    localparam int WORD_W = FLOW_ID_W + NUM_W + tcp_engine_pkg::ACK_KIND_W;

    logic   [WORD_W-1:0]            mem [DEPTH];
    logic   [QUEUE_DEPTH_LOG2:0]    wr_ptr_q;                // top bit is the wrap bit.
    logic   [QUEUE_DEPTH_LOG2:0]    rd_ptr_q;
    logic   [WORD_W-1:0]            rd_word;

    assign q_empty = (wr_ptr_q == rd_ptr_q);
    assign q_full  = ((wr_ptr_q ^ rd_ptr_q) == (QUEUE_DEPTH_LOG2 + 1)'(DEPTH));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (q_wr_en && !q_full) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (q_rd_en && !q_empty) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_wr_en && !q_full) begin
            mem[wr_ptr_q[QUEUE_DEPTH_LOG2-1:0]] <= {q_wr_flowid, q_wr_num, q_wr_kind};
        end
    end

    // the head entry is visible without a read request.
    assign rd_word     = mem[rd_ptr_q[QUEUE_DEPTH_LOG2-1:0]];
    assign q_rd_flowid = rd_word[WORD_W-1 -: FLOW_ID_W];
    assign q_rd_num    = rd_word[tcp_engine_pkg::ACK_KIND_W +: NUM_W];
    assign q_rd_kind   = tcp_engine_pkg::ack_kind_e'(rd_word[tcp_engine_pkg::ACK_KIND_W-1:0]);

endmodule

// File: hw/tcp_engine_pkg.sv
package tcp_engine_pkg;

    localparam int ACK_KIND_W = 2;

    // kind of acknowledgement descriptor pushed into the send queue.
    typedef enum logic [ACK_KIND_W-1:0] {
         ACK_SYN  = 2'd0
        ,ACK_DATA = 2'd1
        ,ACK_DUP  = 2'd2
        ,ACK_RST  = 2'd3
    } ack_kind_e;

    typedef enum logic [2:0] {
         HP_IDLE      = 3'd0
        ,HP_READ      = 3'd1
        ,HP_DECIDE    = 3'd2
        ,HP_ENQ       = 3'd3
        ,HP_WAIT_DROP = 3'd4
    } hdr_proc_state_e;

    typedef enum logic [1:0] {
         EM_IDLE      = 2'd0
        ,EM_REQ       = 2'd1
        ,EM_WAIT_DROP = 2'd2
    } emit_state_e;

endpackage

// File: hw/tcp_hdr_pkg.sv
package tcp_hdr_pkg;

    // sequence and acknowledgement numbers share one 32 bit type.
    typedef logic [31:0] seq_num_t;

    typedef logic [15:0] payload_len_t;     // payload length in bytes.

    // only SYN and FIN are carried on this path.
    typedef logic [1:0] tcp_flags_t;

    localparam int FLAG_SYN_BIT = 0;         // opens a flow.
    localparam int FLAG_FIN_BIT = 1;         // closes a flow after its data.

endpackage

// File: hw/tcp_rx_engine.sv
`timescale 1ns/1ps

module tcp_rx_engine #(
     parameter int FLOW_ID_W        = 4
    ,parameter int QUEUE_DEPTH_LOG2 = 2
)(
     input  logic                       clk
    ,input  logic                       arst_n

    ,input  logic                       hdr_req
    ,input  logic [FLOW_ID_W-1:0]       hdr_flowid
    ,input  tcp_hdr_pkg::seq_num_t      hdr_seq
    ,input  tcp_hdr_pkg::payload_len_t  hdr_len
    ,input  tcp_hdr_pkg::tcp_flags_t    hdr_flags
    ,output logic                       hdr_ack

    ,output logic                       ack_req
    ,output logic [FLOW_ID_W-1:0]       ack_flowid
    ,output tcp_hdr_pkg::seq_num_t      ack_num
    ,output tcp_engine_pkg::ack_kind_e  ack_kind
    ,input  logic                       ack_ack
);

    logic                           st_rd_en;
    logic   [FLOW_ID_W-1:0]         st_rd_flowid;
    logic                           st_rd_open;
    tcp_hdr_pkg::seq_num_t          st_rd_expected;

    logic                           st_wr_en;
    logic   [FLOW_ID_W-1:0]         st_wr_flowid;
    logic                           st_wr_open;
    tcp_hdr_pkg::seq_num_t          st_wr_expected;

    logic                           q_wr_en;
    logic   [FLOW_ID_W-1:0]         q_wr_flowid;
    tcp_hdr_pkg::seq_num_t          q_wr_num;
    tcp_engine_pkg::ack_kind_e      q_wr_kind;
    logic                           q_full;

    logic                           q_rd_en;
    logic                           q_empty;
    logic   [FLOW_ID_W-1:0]         q_rd_flowid;
    tcp_hdr_pkg::seq_num_t          q_rd_num;
    tcp_engine_pkg::ack_kind_e      q_rd_kind;

    recv_state_store #(
         .FLOW_ID_W         (FLOW_ID_W)
    ) recv_state_store (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.st_rd_en          (st_rd_en       )
        ,.st_rd_flowid      (st_rd_flowid   )
        ,.st_wr_en          (st_wr_en       )
        ,.st_wr_flowid      (st_wr_flowid   )
        ,.st_wr_open        (st_wr_open     )
        ,.st_wr_expected    (st_wr_expected )
        ,.st_rd_open        (st_rd_open     )
        ,.st_rd_expected    (st_rd_expected )
    );

    rx_hdr_proc #(
         .FLOW_ID_W         (FLOW_ID_W)
    ) rx_hdr_proc (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.hdr_req           (hdr_req        )
        ,.hdr_flowid        (hdr_flowid     )
        ,.hdr_seq           (hdr_seq        )
        ,.hdr_len           (hdr_len        )
        ,.hdr_flags         (hdr_flags      )
        ,.hdr_ack           (hdr_ack        )
        ,.st_rd_en          (st_rd_en       )
        ,.st_rd_flowid      (st_rd_flowid   )
        ,.st_rd_open        (st_rd_open     )
        ,.st_rd_expected    (st_rd_expected )
        ,.st_wr_en          (st_wr_en       )
        ,.st_wr_flowid      (st_wr_flowid   )
        ,.st_wr_open        (st_wr_open     )
        ,.st_wr_expected    (st_wr_expected )
        ,.q_full            (q_full         )
        ,.q_wr_en           (q_wr_en        )
        ,.q_wr_flowid       (q_wr_flowid    )
        ,.q_wr_num          (q_wr_num       )
        ,.q_wr_kind         (q_wr_kind      )
    );

    rx_send_queue #(
         .FLOW_ID_W         (FLOW_ID_W       )
        ,.QUEUE_DEPTH_LOG2  (QUEUE_DEPTH_LOG2)
    ) rx_send_queue (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.q_wr_en           (q_wr_en        )
        ,.q_wr_flowid       (q_wr_flowid    )
        ,.q_wr_num          (q_wr_num       )
        ,.q_wr_kind         (q_wr_kind      )
        ,.q_full            (q_full         )
        ,.q_rd_en           (q_rd_en        )
        ,.q_empty           (q_empty        )
        ,.q_rd_flowid       (q_rd_flowid    )
        ,.q_rd_num          (q_rd_num       )
        ,.q_rd_kind         (q_rd_kind      )
    );

    ack_emitter #(
         .FLOW_ID_W         (FLOW_ID_W)
    ) ack_emitter (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.q_empty           (q_empty        )
        ,.q_rd_flowid       (q_rd_flowid    )
        ,.q_rd_num          (q_rd_num       )
        ,.q_rd_kind         (q_rd_kind      )
        ,.q_rd_en           (q_rd_en        )
        ,.ack_req           (ack_req        )
        ,.ack_flowid        (ack_flowid     )
        ,.ack_num           (ack_num        )
        ,.ack_kind          (ack_kind       )
        ,.ack_ack           (ack_ack        )
    );

endmodule

// File: tcp_rx_engine.f
hw/tcp_hdr_pkg.sv
hw/tcp_engine_pkg.sv
hw/recv_state_store.sv
hw/rx_hdr_proc.sv
hw/rx_send_queue.sv
hw/ack_emitter.sv
hw/tcp_rx_engine.sv
verification/tcp_rx_engine_checks.sv
verification/tcp_rx_engine_tb.sv

// File: verification/tcp_rx_engine_checks.sv
package tcp_rx_engine_checks;

    int value_errors    = 0;
    int protocol_errors = 0;                                // timeouts and handshake faults.

    // flow ids are FLOW_ID_W wide in the DUT and arrive here zero extended.
    task automatic check_flowid(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_num(input string name, input tcp_hdr_pkg::seq_num_t exp,
                             input tcp_hdr_pkg::seq_num_t act);
        if (exp !== act) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_kind(input string name, input tcp_engine_pkg::ack_kind_e exp,
                              input tcp_engine_pkg::ack_kind_e act);
        if (exp !== act) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
            value_errors++;
        end
    endtask

    // samples 1 ns after each rising edge, where registered outputs are settled.
    task automatic wait_level(ref logic clk, ref logic sig, input logic level,
                              input int max_cycles, input string what, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < max_cycles) begin
            @(posedge clk);
            #1ns;
            ok = (sig === level);
            n++;
        end
        if (!ok) begin
            $display("ERROR: timed out after %0d cycles waiting for %s", max_cycles, what);
            protocol_errors++;
        end
    endtask

    task automatic expect_stays(ref logic clk, ref logic sig, input logic level,
                                input int cycles, input string what);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge clk);
            #1ns;
            if (sig !== level) begin
                $display("ERROR: %s changed after %0d of %0d cycles", what, n + 1, cycles);
                protocol_errors++;
                break;
            end
        end
    endtask

endpackage

// File: verification/tcp_rx_engine_tb.sv
`timescale 1ns/1ps

module tcp_rx_engine_tb;

    localparam int FLOW_ID_W        = 4;
    localparam int QUEUE_DEPTH_LOG2 = 2;
    localparam int DEPTH            = 1 << QUEUE_DEPTH_LOG2;

    localparam tcp_hdr_pkg::tcp_flags_t F_NONE = 2'b00;
    localparam tcp_hdr_pkg::tcp_flags_t F_SYN  = 2'b01 << tcp_hdr_pkg::FLAG_SYN_BIT;
    localparam tcp_hdr_pkg::tcp_flags_t F_FIN  = 2'b01 << tcp_hdr_pkg::FLAG_FIN_BIT;

    typedef struct packed {
        logic [FLOW_ID_W-1:0]       flowid;         // the reply goes back on the same flow.
        tcp_hdr_pkg::seq_num_t      seq;
        tcp_hdr_pkg::payload_len_t  len;
        tcp_hdr_pkg::tcp_flags_t    flags;
        tcp_hdr_pkg::seq_num_t      exp_num;
        tcp_engine_pkg::ack_kind_e  exp_kind;
    } row_t;

    logic                       clk;
    logic                       arst_n;
    logic                       hdr_req;
    logic [FLOW_ID_W-1:0]       hdr_flowid;
    tcp_hdr_pkg::seq_num_t      hdr_seq;
    tcp_hdr_pkg::payload_len_t  hdr_len;
    tcp_hdr_pkg::tcp_flags_t    hdr_flags;
    logic                       hdr_ack;
    logic                       ack_req;
    logic [FLOW_ID_W-1:0]       ack_flowid;
    tcp_hdr_pkg::seq_num_t      ack_num;
    tcp_engine_pkg::ack_kind_e  ack_kind;
    logic                       ack_ack;
    logic                       hold_ack;           // sink withholds ack_ack while set.

    row_t   rows [$];
    int     bp_start;                               // first row of the back-pressure phase.
    int     rx_count;

    tcp_rx_engine #(
         .FLOW_ID_W         (FLOW_ID_W)
        ,.QUEUE_DEPTH_LOG2  (QUEUE_DEPTH_LOG2)
    ) u_dut (.*);

    always #10 clk = ~clk;

    function automatic void add_row(input logic [FLOW_ID_W-1:0] flowid,
                                    input tcp_hdr_pkg::seq_num_t seq,
                                    input tcp_hdr_pkg::payload_len_t len,
                                    input tcp_hdr_pkg::tcp_flags_t flags,
                                    input tcp_hdr_pkg::seq_num_t num,
                                    input tcp_engine_pkg::ack_kind_e kind);
        rows.push_back('{flowid, seq, len, flags, num, kind});
    endfunction

    function automatic void fill_table();
        add_row(3, 32'h0000_1000, 16'h0000, F_SYN,  32'h0000_1001, tcp_engine_pkg::ACK_SYN);
        add_row(5, 32'h8000_0000, 16'h0000, F_SYN,  32'h8000_0001, tcp_engine_pkg::ACK_SYN);
        add_row(3, 32'h0000_1001, 16'h0020, F_NONE, 32'h0000_1021, tcp_engine_pkg::ACK_DATA);
        add_row(3, 32'h0000_1021, 16'h0010, F_NONE, 32'h0000_1031, tcp_engine_pkg::ACK_DATA);
        add_row(5, 32'h8000_0001, 16'h0100, F_NONE, 32'h8000_0101, tcp_engine_pkg::ACK_DATA);
        add_row(3, 32'h0000_1100, 16'h0010, F_NONE, 32'h0000_1031, tcp_engine_pkg::ACK_DUP);
        add_row(3, 32'h0000_1031, 16'h0008, F_NONE, 32'h0000_1039, tcp_engine_pkg::ACK_DATA);
        add_row(3, 32'h0000_1039, 16'h0004, F_FIN,  32'h0000_103e, tcp_engine_pkg::ACK_DATA);
        add_row(3, 32'h0000_103e, 16'h0010, F_NONE, 32'h0000_0000, tcp_engine_pkg::ACK_RST);
        add_row(9, 32'h0000_2000, 16'h0010, F_NONE, 32'h0000_0000, tcp_engine_pkg::ACK_RST);
        add_row(5, 32'h8000_0101, 16'h0000, F_FIN,  32'h8000_0102, tcp_engine_pkg::ACK_DATA);
        bp_start = rows.size();
        // the sequence space wraps on flow 7 and the last row stalls on the full queue.
        add_row(7, 32'hffff_fff0, 16'h0000, F_SYN,  32'hffff_fff1, tcp_engine_pkg::ACK_SYN);
        add_row(7, 32'hffff_fff1, 16'h0010, F_NONE, 32'h0000_0001, tcp_engine_pkg::ACK_DATA);
        add_row(7, 32'h0000_0001, 16'h0002, F_NONE, 32'h0000_0003, tcp_engine_pkg::ACK_DATA);
        add_row(2, 32'h0000_0000, 16'h0000, F_SYN,  32'h0000_0001, tcp_engine_pkg::ACK_SYN);
        add_row(7, 32'h0000_0003, 16'h0004, F_NONE, 32'h0000_0007, tcp_engine_pkg::ACK_DATA);
        add_row(2, 32'h0000_0001, 16'h0030, F_NONE, 32'h0000_0031, tcp_engine_pkg::ACK_DATA);
    endfunction

    task automatic send_header(input int idx, input bit expect_stall, output bit ok);
        hdr_flowid = rows[idx].flowid;
        hdr_seq    = rows[idx].seq;
        hdr_len    = rows[idx].len;
        hdr_flags  = rows[idx].flags;
        hdr_req    = 1'b1;
        if (expect_stall) begin
            tcp_rx_engine_checks::expect_stays(clk, hdr_ack, 1'b0, 50, "hdr_ack on a full queue");
            hold_ack = 1'b0;
        end
        tcp_rx_engine_checks::wait_level(clk, hdr_ack, 1'b1, 100, "hdr_ack to rise", ok);
        if (ok) begin
            hdr_req = 1'b0;
            tcp_rx_engine_checks::wait_level(clk, hdr_ack, 1'b0, 10, "hdr_ack to fall", ok);
        end
    endtask

    task automatic collect_acks();
        int i;
        int delay;
        bit ok;
        for (i = 0; i < rows.size(); i++) begin
            tcp_rx_engine_checks::wait_level(clk, ack_req, 1'b1, 400, "ack_req to rise", ok);
            if (!ok) break;
            tcp_rx_engine_checks::check_flowid("ack_flowid", rows[i].flowid, ack_flowid);
            tcp_rx_engine_checks::check_num("ack_num", rows[i].exp_num, ack_num);
            tcp_rx_engine_checks::check_kind("ack_kind", rows[i].exp_kind, ack_kind);
            delay = $urandom_range(5, 0);
            repeat (delay) @(posedge clk);
            if (hold_ack) begin
                tcp_rx_engine_checks::wait_level(clk, hold_ack, 1'b0, 400, "sink release", ok);
                if (!ok) break;
            end
            #1 ack_ack = 1'b1;
            tcp_rx_engine_checks::wait_level(clk, ack_req, 1'b0, 10, "ack_req to fall", ok);
            ack_ack = 1'b0;
            rx_count++;
            if (!ok) break;
        end
    endtask

    initial begin
        bit ok;
        int i;
        int n;
        void'($urandom(32'h9f43_84cb));
        clk        = 1'b0;
        arst_n     = 1'b0;
        hdr_req    = 1'b0;
        hdr_flowid = '0;
        hdr_seq    = '0;
        hdr_len    = '0;
        hdr_flags  = '0;
        ack_ack    = 1'b0;
        hold_ack   = 1'b0;
        rx_count   = 0;
        fill_table();
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        fork
            collect_acks();
            begin
                for (i = 0; i < rows.size(); i++) begin
                    if (i == bp_start) begin
                        n = 0;
                        while (rx_count < bp_start && n < 400) begin
                            @(posedge clk);
                            #1;
                            n++;
                        end
                        if (rx_count < bp_start) begin
                            $display("ERROR: earlier acknowledgements never drained");
                            tcp_rx_engine_checks::protocol_errors++;
                            break;
                        end
                        hold_ack = 1'b1;            // one held in the emitter, DEPTH queued.
                    end
                    send_header(i, i == bp_start + DEPTH + 1, ok);
                    if (!ok) break;
                end
            end
        join
        $display("error counts: %0d value mismatches, %0d handshake errors",
                 tcp_rx_engine_checks::value_errors, tcp_rx_engine_checks::protocol_errors);
        if (tcp_rx_engine_checks::value_errors == 0
                && tcp_rx_engine_checks::protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
